// ==== source/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address and memory index
`define FETCH_ADDR_W      48     // PC width
`define FETCH_INDEX_W     19     // Memory index, PC bits 21 down to 3

// Response beats
`define FETCH_BEAT_W      64     // One beat on the response bus
`define FETCH_BEATS       8      // Beats per line

// Instructions
`define FETCH_INST_W      32
`define FETCH_LINE_INSTS  16     // Instructions per line

// Line size in bytes, also the sequential PC step
`define FETCH_LINE_BYTES  64

`endif

// ==== source/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

    // Byte address of the fetch path
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // Line index sent to memory
    typedef logic [`FETCH_INDEX_W-1:0] index_t;

    // One response beat
    typedef logic [`FETCH_BEAT_W-1:0] beat_t;

    // One instruction word
    typedef logic [`FETCH_INST_W-1:0] inst_t;

    // One cache line, filled by beat and read by instruction
    // Beat k carries instruction 2k in its low half, 2k+1 in its high half
    typedef union packed {
        beat_t [`FETCH_BEATS-1:0]      beats;  // Write view of line_fill
        inst_t [`FETCH_LINE_INSTS-1:0] insts;  // Read view of inst_buffer
    } fetch_line_u;

endpackage

// ==== source/pc_ctrl.sv ====
`include "fetch_settings.svh"

module pc_ctrl (
    input  logic              clock,
    input  logic              reset_n,

    input  fetch_pkg::addr_t  boot_addr,          // PC after reset
    input  logic              interrupt_valid,
    input  fetch_pkg::addr_t  interrupt_addr,
    input  logic              redirect_valid,
    input  fetch_pkg::addr_t  redirect_target,

    input  logic              fetch_inst,         // Buffer asks for a line
    output logic              can_fetch_inst,     // No line in flight for the buffer
    output logic              clear_ibuffer,      // One cycle on every jump
    output fetch_pkg::addr_t  pc,                 // Address of the line in flight

    output logic              mem_req_valid,
    output fetch_pkg::index_t mem_req_index,
    input  logic              mem_req_ready,
    output logic              req_accepted,       // Request transfer this cycle
    input  logic              pc_operation_done   // A kept line has been delivered
);
    import fetch_pkg::*;

    addr_t seq_pc;        // Next line in program order
    logic  fetch_inst_q;  // fetch_inst one cycle back
    logic  fetch_rise;
    logic  line_done;

    assign seq_pc     = pc + addr_t'(`FETCH_LINE_BYTES);
    assign fetch_rise = fetch_inst && !fetch_inst_q;  // Only the first cycle of a request counts

    assign mem_req_index = pc[`FETCH_INDEX_W+2:3];
    assign req_accepted  = mem_req_valid && mem_req_ready;

    // A completion in the clear cycle is the old line that the jump has dropped
    assign line_done = pc_operation_done && !clear_ibuffer;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_inst_q <= 1'b0;
        end else begin
            fetch_inst_q <= fetch_inst;
        end
    end

    // Jumps first, then the sequential step, then the handshake and line completion
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc             <= boot_addr;
            mem_req_valid  <= 1'b0;
            can_fetch_inst <= 1'b1;
            clear_ibuffer  <= 1'b0;
        end else begin
            clear_ibuffer <= 1'b0;                // Pulse unless a jump below
            if (interrupt_valid) begin
                pc             <= interrupt_addr;
                mem_req_valid  <= 1'b1;           // Replaces any request not yet sent
                can_fetch_inst <= 1'b0;
                clear_ibuffer  <= 1'b1;
            end else if (redirect_valid) begin
                pc             <= redirect_target;
                mem_req_valid  <= 1'b1;
                can_fetch_inst <= 1'b0;
                clear_ibuffer  <= 1'b1;
            end else if (fetch_rise) begin
                pc             <= seq_pc;         // Step before the request goes out
                mem_req_valid  <= 1'b1;
                can_fetch_inst <= 1'b0;
            end else if (req_accepted) begin
                mem_req_valid  <= 1'b0;           // Line is now with memory
            end else if (line_done) begin
                can_fetch_inst <= 1'b1;
            end
        end
    end

endmodule

// ==== source/line_fill.sv ====
`include "fetch_settings.svh"

module line_fill (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   req_accepted,       // Memory took a request
    input  logic                   clear_ibuffer,      // Jump, all lines in flight go stale
    input  fetch_pkg::addr_t       pc,                 // Line address of the request
    input  logic                   mem_rsp_valid,
    input  fetch_pkg::beat_t       mem_rsp_data,
    output logic                   pc_operation_done,
    output logic                   line_valid,
    output fetch_pkg::fetch_line_u line_data,
    output fetch_pkg::addr_t       line_pc
);
    import fetch_pkg::*;

    localparam int BEAT_CNT_W  = $clog2(`FETCH_BEATS);
    localparam int QUEUE_DEPTH = 8;                    // Requests in flight at most
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int CNT_W       = QPTR_W + 1;
    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(`FETCH_BEATS - 1);

    addr_t                 pc_queue [QUEUE_DEPTH];     // Line address per accepted request
    logic [QPTR_W-1:0]     q_wr_ptr;
    logic [QPTR_W-1:0]     q_rd_ptr;
    logic [CNT_W-1:0]      live_cnt;                   // Lines still wanted
    logic [CNT_W-1:0]      stale_cnt;                  // Older lines to throw away
    logic [BEAT_CNT_W-1:0] beat_cnt;                   // Beat number inside the head line
    logic                  head_stale;
    logic                  beat_kept;
    logic                  line_end;

    // Lines come back in order, so stale lines are always the oldest
    assign head_stale = (stale_cnt != '0) || clear_ibuffer;
    assign beat_kept  = mem_rsp_valid && !head_stale;
    assign line_end   = mem_rsp_valid && (beat_cnt == LAST_BEAT);

    assign pc_operation_done = line_valid;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            live_cnt  <= '0;
            stale_cnt <= '0;
        end else if (clear_ibuffer) begin
            // Everything accepted so far is dropped, a request sent now is the new target
            stale_cnt <= stale_cnt + live_cnt - CNT_W'(line_end);
            live_cnt  <= CNT_W'(req_accepted);
        end else begin
            if (line_end && (stale_cnt != '0)) begin
                stale_cnt <= stale_cnt - 1'b1;
            end
            live_cnt <= live_cnt + CNT_W'(req_accepted)
                        - CNT_W'(line_end && (stale_cnt == '0));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            q_wr_ptr   <= '0;
            q_rd_ptr   <= '0;
            beat_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            if (req_accepted) q_wr_ptr <= q_wr_ptr + 1'b1;
            if (line_end) q_rd_ptr <= q_rd_ptr + 1'b1;  // Pop kept and stale lines alike
            if (mem_rsp_valid) beat_cnt <= beat_cnt + 1'b1;
            line_valid <= beat_kept && line_end;
        end
    end

    always_ff @(posedge clock) begin
        if (req_accepted) begin
            pc_queue[q_wr_ptr] <= pc;
        end
    end

    // Kept beats land in their slot of the line
    always_ff @(posedge clock) begin
        if (beat_kept) begin
            line_data.beats[beat_cnt] <= mem_rsp_data;
        end
        if (beat_kept && line_end) begin
            line_pc <= pc_queue[q_rd_ptr];             // Address that goes with this line
        end
    end

endmodule

// ==== source/inst_buffer.sv ====
`include "fetch_settings.svh"

module inst_buffer (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   line_valid,      // Complete line from line_fill
    input  fetch_pkg::fetch_line_u line_data,
    input  fetch_pkg::addr_t       line_pc,
    input  logic                   clear_ibuffer,   // Jump, drop the held line
    input  logic                   can_fetch_inst,
    input  logic                   inst_ready,      // Decode takes the instruction
    output logic                   fetch_inst,      // Buffer wants the next line
    output logic                   inst_valid,
    output fetch_pkg::inst_t       inst_data,
    output fetch_pkg::addr_t       inst_pc
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`FETCH_LINE_INSTS);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`FETCH_LINE_INSTS - 1);
    localparam int INST_BYTES = `FETCH_INST_W / 8;

    fetch_line_u      line_buf;   // Held line
    addr_t            line_base;  // Address of instruction 0
    logic [PTR_W-1:0] rd_ptr;     // Next instruction to hand out
    logic             inst_take;
    logic             line_load;

    assign inst_take = inst_valid && inst_ready;
    assign line_load = line_valid && !clear_ibuffer;  // Line racing a clear is old

    // Decode side view of the current slot
    assign inst_data = line_buf.insts[rd_ptr];
    assign inst_pc   = line_base + addr_t'(rd_ptr) * INST_BYTES;

    // Ask only when empty, allowed and not in a jump cycle
    assign fetch_inst = !inst_valid && can_fetch_inst && !clear_ibuffer;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            inst_valid <= 1'b0;
            rd_ptr     <= '0;
        end else if (clear_ibuffer) begin
            inst_valid <= 1'b0;            // Empty in the next cycle
            rd_ptr     <= '0;
        end else if (line_load) begin
            inst_valid <= 1'b1;
            rd_ptr     <= '0;
        end else if (inst_take) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (rd_ptr == LAST_SLOT) begin
                inst_valid <= 1'b0;        // Sixteenth taken, line used up
            end
        end
    end

    // Line payload, loaded whole
    always_ff @(posedge clock) begin
        if (line_load) begin
            line_buf  <= line_data;
            line_base <= line_pc;
        end
    end

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit (
    input  logic              clock,
    input  logic              reset_n,
    input  fetch_pkg::addr_t  boot_addr,
    input  logic              interrupt_valid,
    input  fetch_pkg::addr_t  interrupt_addr,
    input  logic              redirect_valid,
    input  fetch_pkg::addr_t  redirect_target,

    // Memory request and response
    output logic              mem_req_valid,
    output fetch_pkg::index_t mem_req_index,
    input  logic              mem_req_ready,
    input  logic              mem_rsp_valid,
    input  fetch_pkg::beat_t  mem_rsp_data,

    // Decode side
    output logic              inst_valid,
    output fetch_pkg::inst_t  inst_data,
    output fetch_pkg::addr_t  inst_pc,
    input  logic              inst_ready
);
    import fetch_pkg::*;

    logic        can_fetch_inst;
    logic        clear_ibuffer;
    logic        fetch_inst;
    logic        req_accepted;
    logic        pc_operation_done;
    logic        line_valid;
    addr_t       pc;
    addr_t       line_pc;
    fetch_line_u line_data;

    // Control, PC and memory request
    pc_ctrl u_pc_ctrl (
        .clock             (clock),
        .reset_n           (reset_n),
        .boot_addr         (boot_addr),
        .interrupt_valid   (interrupt_valid),
        .interrupt_addr    (interrupt_addr),
        .redirect_valid    (redirect_valid),
        .redirect_target   (redirect_target),
        .fetch_inst        (fetch_inst),
        .can_fetch_inst    (can_fetch_inst),
        .clear_ibuffer     (clear_ibuffer),
        .pc                (pc),
        .mem_req_valid     (mem_req_valid),
        .mem_req_index     (mem_req_index),
        .mem_req_ready     (mem_req_ready),
        .req_accepted      (req_accepted),
        .pc_operation_done (pc_operation_done)
    );

    // Beats to lines
    line_fill u_line_fill (
        .clock             (clock),
        .reset_n           (reset_n),
        .req_accepted      (req_accepted),
        .clear_ibuffer     (clear_ibuffer),
        .pc                (pc),
        .mem_rsp_valid     (mem_rsp_valid),
        .mem_rsp_data      (mem_rsp_data),
        .pc_operation_done (pc_operation_done),
        .line_valid        (line_valid),
        .line_data         (line_data),
        .line_pc           (line_pc)
    );

    // Lines to instructions
    inst_buffer u_inst_buffer (
        .clock          (clock),
        .reset_n        (reset_n),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .line_pc        (line_pc),
        .clear_ibuffer  (clear_ibuffer),
        .can_fetch_inst (can_fetch_inst),
        .inst_ready     (inst_ready),
        .fetch_inst     (fetch_inst),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .inst_pc        (inst_pc)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // Period of 4
    end

    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clock);
        #1 reset_n = 1'b1;          // Release just after the eighth edge
    end

endmodule

// ==== test/fetch_tb.sv ====
`include "fetch_settings.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [31:0] SEED        = 32'h9eea7a36;
    localparam addr_t       BOOT_PC     = 48'h00ab_cdef_1000;
    localparam int          RUN_INSTS   = 400;
    localparam int          LINE_CYCLES = 64;  // Rough cost of one line with stalls and jumps
    localparam int          TIMEOUT     = 4 * (RUN_INSTS / `FETCH_LINE_INSTS + 1) * LINE_CYCLES;

    logic   clock, reset_n;
    logic   interrupt_valid, redirect_valid;
    addr_t  interrupt_addr, redirect_target;
    logic   mem_req_valid, mem_req_ready, mem_rsp_valid;
    index_t mem_req_index;
    beat_t  mem_rsp_data;
    logic   inst_valid, inst_ready;
    inst_t  inst_data;
    addr_t  inst_pc;

    logic [31:0] lfsr;                   // Random source
    index_t      rsp_queue [$];          // Accepted indices, answered in order
    int          rsp_beat, rsp_wait;
    addr_t       exp_pc, next_req_pc;    // Next taken address, next requested line
    addr_t       jump_target, held_pc;
    logic        jump_pending, inst_stalled, req_stalled;
    inst_t       held_data;
    index_t      held_index;
    int          taken, jumps, cycles;

    tb_clock_gen u_clock_gen (.clock(clock), .reset_n(reset_n));

    fetch_unit UUT (
        .clock(clock), .reset_n(reset_n), .boot_addr(BOOT_PC),
        .interrupt_valid(interrupt_valid), .interrupt_addr(interrupt_addr),
        .redirect_valid(redirect_valid), .redirect_target(redirect_target),
        .mem_req_valid(mem_req_valid), .mem_req_index(mem_req_index),
        .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_data(mem_rsp_data), .inst_valid(inst_valid), .inst_data(inst_data),
        .inst_pc(inst_pc), .inst_ready(inst_ready)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) value = {value[62:0], lfsr_bit()};
        return value;
    endfunction

    // Memory contents, instruction per line index and slot
    function automatic inst_t model_inst(input index_t index, input logic [3:0] slot);
        return {index, slot, 9'h000} ^ 32'h6b3d_a5c7;
    endfunction

    function automatic index_t index_of(input addr_t addr);
        return addr[`FETCH_INDEX_W+2:3];
    endfunction

    // Beat k carries slot 2k low and slot 2k+1 high
    function automatic beat_t beat_value(input index_t index, input int beat);
        return {model_inst(index, 4'(2 * beat + 1)), model_inst(index, 4'(2 * beat))};
    endfunction

    function automatic inst_t expected_inst(input addr_t addr);
        addr_t line_addr;
        line_addr = addr & ~addr_t'(`FETCH_LINE_BYTES - 1);
        return model_inst(index_of(line_addr), addr[5:2]);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected 0x%0h got 0x%0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // New inputs for the next cycle, memory beats included
    task automatic drive_inputs();
        logic [1:0] kind;
        interrupt_valid = 1'b0;
        redirect_valid  = 1'b0;
        if (rand_bits(7) == 0) begin  // Rare jump
            kind            = 2'(rand_bits(2));
            interrupt_addr  = {42'(rand_bits(42)), 6'b0};
            redirect_target = {42'(rand_bits(42)), 6'b0};
            interrupt_valid = (kind == 2'd0) || (kind == 2'd2);
            redirect_valid  = (kind != 2'd0);  // Kind 2 raises both
        end
        mem_req_ready = (rand_bits(2) != 0);
        inst_ready    = (rand_bits(2) != 0);
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        if (rsp_queue.size() != 0) begin
            if (rsp_wait != 0) begin
                rsp_wait--;
            end else if (rand_bits(2) != 0) begin  // Random gap between beats
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = beat_value(rsp_queue[0], rsp_beat);
                rsp_beat++;
                if (rsp_beat == `FETCH_BEATS) begin
                    void'(rsp_queue.pop_front());
                    rsp_beat = 0;
                    rsp_wait = int'(rand_bits(2));
                end
            end
        end
    endtask

    // Sampled mid cycle, model steps for the coming edge
    task automatic observe_edge();
        logic in_clear;
        in_clear = jump_pending;  // Cycle after a jump pulse, buffer empties at its edge
        if (inst_stalled) begin
            check_value("inst_valid", 1, inst_valid);
            check_value("inst_pc", held_pc, inst_pc);
            check_value("inst_data", held_data, inst_data);
        end
        if (req_stalled) begin
            check_value("mem_req_valid", 1, mem_req_valid);
            check_value("mem_req_index", held_index, mem_req_index);
        end
        if (mem_req_valid && mem_req_ready) begin
            check_value("mem_req_index", index_of(next_req_pc), mem_req_index);
            if (rsp_queue.size() == 0) rsp_wait = int'(rand_bits(3));
            rsp_queue.push_back(mem_req_index);
            next_req_pc = next_req_pc + `FETCH_LINE_BYTES;  // Next line in order
        end
        if (inst_valid && inst_ready) begin
            check_value("inst_pc", exp_pc, inst_pc);
            check_value("inst_data", expected_inst(exp_pc), inst_data);
            exp_pc = exp_pc + 4;
            taken++;
        end
        // Old stream may still be taken during the clear cycle
        if (jump_pending) begin
            exp_pc       = jump_target;
            jump_pending = 1'b0;
        end
        if (interrupt_valid || redirect_valid) begin
            jump_target  = interrupt_valid ? interrupt_addr : redirect_target;  // Interrupt first
            jump_pending = 1'b1;
            next_req_pc  = jump_target;
            jumps++;
        end
        inst_stalled = inst_valid && !inst_ready && !in_clear;
        held_pc      = inst_pc;
        held_data    = inst_data;
        req_stalled  = mem_req_valid && !mem_req_ready && !interrupt_valid && !redirect_valid;
        held_index   = mem_req_index;
    endtask

    initial begin
        interrupt_valid = 1'b0;
        redirect_valid  = 1'b0;
        interrupt_addr  = '0;
        redirect_target = '0;
        mem_req_ready   = 1'b0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_data    = '0;
        inst_ready      = 1'b0;
        lfsr            = SEED;
        rsp_beat        = 0;
        rsp_wait        = 0;
        exp_pc          = BOOT_PC + `FETCH_LINE_BYTES;  // PC steps before the first request
        next_req_pc     = BOOT_PC + `FETCH_LINE_BYTES;
        jump_pending    = 1'b0;
        inst_stalled    = 1'b0;
        req_stalled     = 1'b0;
        taken           = 0;
        jumps           = 0;
        cycles          = 0;
        wait (reset_n === 1'b1);
        @(negedge clock);
        check_value("mem_req_valid", 0, mem_req_valid);
        check_value("inst_valid", 0, inst_valid);
        while (taken < RUN_INSTS) begin
            observe_edge();
            @(posedge clock);
            #1;
            drive_inputs();
            @(negedge clock);
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("Timeout after %0d cycles with %0d of %0d instructions taken",
                         cycles, taken, RUN_INSTS);
                $display("Testbench failed");
                $fatal(1, "Run did not finish in time");
            end
        end
        if (jumps == 0) begin
            $display("No interrupt or redirect was exercised during the run");
            $display("Testbench failed");
            $fatal(1, "Run ended without a jump");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
+incdir+source
source/fetch_pkg.sv
source/pc_ctrl.sv
source/line_fill.sv
source/inst_buffer.sv
source/fetch_unit.sv
test/tb_clock_gen.sv
test/fetch_tb.sv
